//--- crypto_bus_pkg.sv
`default_nettype none

package crypto_bus_pkg;

   localparam int unsigned ADDR_W    = 32;
   localparam int unsigned DATA_W    = 32;
   localparam int unsigned SEL_W     = 4;
   localparam int unsigned NR_SLAVES = 4;

   // Range widths run from 1 to ADDR_W
   localparam int unsigned RANGE_W_W = $clog2(ADDR_W + 1);

   // Master to slave request, Wishbone classic without cab/cti/bte
   typedef struct packed {
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
      logic [SEL_W-1:0]  sel;
      logic              we;
      logic              cyc;
      logic              stb;
   } wb_m2s_t;

   // Slave to master response
   typedef struct packed {
      logic [DATA_W-1:0] dat;
      logic              ack;
      logic              err;
   } wb_s2m_t;

   // Target slot of a request, in decode priority order
   typedef enum logic [2:0] {
      SLV_DES3 = 3'd0,
      SLV_SHA  = 3'd1,
      SLV_NA   = 3'd2,
      SLV_AES  = 3'd3,
      SLV_NONE = 3'd4    // No enabled range matched
   } slave_e;

   typedef enum logic [1:0] {
      BUS_IDLE = 2'd0,   // Ready for a new access
      BUS_WAIT = 2'd1,   // Slave selected, waiting on ack/err
      BUS_ERR  = 2'd2    // Fabric answers with its own err
   } bus_state_e;

endpackage

`default_nettype wire

//--- crypto_bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module crypto_bus_decode
   import crypto_bus_pkg::*;
#(
   // Per slot number of top address bits that take part in the match
   parameter logic [NR_SLAVES-1:0][RANGE_W_W-1:0] RANGE_WIDTH = '0,
   // Per slot match value, right aligned
   parameter logic [NR_SLAVES-1:0][ADDR_W-1:0]    RANGE_MATCH = '0,
   parameter logic [NR_SLAVES-1:0]                ENABLE      = '0
) (
   input  wire  [ADDR_W-1:0] adr_i,
   output slave_e            sel_slave_o
);

   logic [NR_SLAVES-1:0] hit;   // One bit per slot whose range covers adr_i

   for (genvar i = 0; i < NR_SLAVES; i++) begin : gen_slot
      // Bits below the compared field
      localparam int SHIFT = int'(ADDR_W) - int'(RANGE_WIDTH[i]);
      localparam logic [ADDR_W-1:0] MASK = {ADDR_W{1'b1}} >> SHIFT;

      if (ENABLE[i] && (RANGE_WIDTH[i] == 0 || RANGE_WIDTH[i] > ADDR_W)) begin : gen_bad_width
         $error("Slot %0d range width %0d out of 1..%0d", i, RANGE_WIDTH[i], ADDR_W);
      end

      // Extra match bits above the field are ignored
      assign hit[i] = ENABLE[i] && ((adr_i >> SHIFT) == (RANGE_MATCH[i] & MASK));
   end

   // Walk down so the lowest matching slot is the last one written
   always_comb begin
      sel_slave_o = SLV_NONE;
      for (int i = NR_SLAVES - 1; i >= 0; i--) begin
         if (hit[i]) begin
            sel_slave_o = slave_e'(i[2:0]);
         end
      end
   end

endmodule

`default_nettype wire

//--- crypto_bus_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module crypto_bus_fabric
   import crypto_bus_pkg::*;
#(
   parameter int unsigned TIMEOUT_CYCLES = 16
) (
   input  wire          clk,
   input  wire          arst_n_i,

   input  wire wb_m2s_t m_req_i,
   input  wire slave_e  sel_slave_i,      // From the decoder, same cycle
   output wb_s2m_t      m_rsp_o,

   output wb_m2s_t      s_req_o [NR_SLAVES],
   input  wire wb_s2m_t s_rsp_i [NR_SLAVES]
);

   // Counter runs 0 .. TIMEOUT_CYCLES-2 while in BUS_WAIT
   localparam int unsigned CNT_W = (TIMEOUT_CYCLES > 2) ? $clog2(TIMEOUT_CYCLES - 1) : 1;
   localparam int unsigned IDX_W = (NR_SLAVES > 1) ? $clog2(NR_SLAVES) : 1;

   if (TIMEOUT_CYCLES < 2) begin : gen_bad_timeout
      $error("TIMEOUT_CYCLES must be 2 or more, got %0d", TIMEOUT_CYCLES);
   end

   bus_state_e           state_q;
   bus_state_e           state_d;
   logic [CNT_W-1:0]     cnt_q;          // Watchdog
   logic [CNT_W-1:0]     cnt_d;
   slave_e               slave_q;        // Slot held across a waited access
   slave_e               cur_slave;
   logic                 req;
   logic                 cur_valid;
   logic                 cur_done;
   logic                 routed;
   wb_s2m_t              cur_rsp;
   logic [NR_SLAVES-1:0] s_stb;

   assign req       = m_req_i.cyc && m_req_i.stb;
   assign cur_slave = (state_q == BUS_WAIT) ? slave_q : sel_slave_i;
   assign cur_valid = (cur_slave != SLV_NONE);
   assign routed    = (state_q == BUS_IDLE) || (state_q == BUS_WAIT);

   // Response of the slot in use, zero when nothing is selected
   assign cur_rsp  = cur_valid ? s_rsp_i[cur_slave[IDX_W-1:0]] : '0;
   assign cur_done = req && cur_valid && (cur_rsp.ack || cur_rsp.err);

   // Address and data fan out, cyc/stb only to the selected slot
   always_comb begin
      for (int i = 0; i < NR_SLAVES; i++) begin
         s_req_o[i]     = m_req_i;
         s_req_o[i].cyc = 1'b0;
         s_req_o[i].stb = 1'b0;
         if (routed && (int'(cur_slave) == i)) begin
            s_req_o[i].cyc = m_req_i.cyc;
            s_req_o[i].stb = m_req_i.stb;
         end
      end
   end

   for (genvar i = 0; i < NR_SLAVES; i++) begin : gen_stb
      assign s_stb[i] = s_req_o[i].stb;
   end

   // Slave answer passes straight through, fabric err has dat at zero
   always_comb begin
      m_rsp_o = '0;
      if (state_q == BUS_ERR) begin
         m_rsp_o.err = 1'b1;
      end else if (req) begin
         m_rsp_o = cur_rsp;
      end
   end

   always_comb begin
      state_d = state_q;
      cnt_d   = cnt_q;
      case (state_q)
         BUS_IDLE: begin
            cnt_d = '0;
            if (req) begin
               if (!cur_valid) begin
                  state_d = BUS_ERR;           // Unmapped address
               end else if (!cur_done) begin
                  state_d = BUS_WAIT;          // Slave needs more cycles
               end
            end
         end
         BUS_WAIT: begin
            if (!req || cur_done) begin
               state_d = BUS_IDLE;             // Answered, or master gave up
            end else if (cnt_q == CNT_W'(TIMEOUT_CYCLES - 2)) begin
               state_d = BUS_ERR;              // Watchdog fired
            end else begin
               cnt_d = cnt_q + 1'b1;
            end
         end
         BUS_ERR: begin
            state_d = BUS_IDLE;
            cnt_d   = '0;
         end
         default: begin
            state_d = BUS_IDLE;
            cnt_d   = '0;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= BUS_IDLE;
         cnt_q   <= '0;
         slave_q <= SLV_NONE;
      end else begin
         state_q <= state_d;
         cnt_q   <= cnt_d;
         if (state_q == BUS_IDLE) begin
            slave_q <= sel_slave_i;            // Latch target on access start
         end
      end
   end

   a_one_stb: assert property (@(posedge clk) disable iff (!arst_n_i)
      $onehot0(s_stb))
      else $error("More than one slave stb high");

   a_ack_err_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
      !(m_rsp_o.ack && m_rsp_o.err))
      else $error("ack and err together on master port");

   // Fabric err lasts one cycle and any err after it comes from a slave
   a_err_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
      (state_q == BUS_ERR) |=> (!m_rsp_o.err || (req && cur_rsp.err)))
      else $error("Fabric err not a one cycle pulse");

endmodule

`default_nettype wire

//--- cryptosubsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module cryptosubsys_top
   import crypto_bus_pkg::*;
#(
   // DES3 at 0x00000000-0x7fffffff
   parameter bit                DES3_ENABLE      = 1'b1,
   parameter int unsigned       DES3_RANGE_WIDTH = 1,
   parameter logic [ADDR_W-1:0] DES3_RANGE_MATCH = 'h0,

   // SHA at 0xd0000000-0xdfffffff
   parameter bit                SHA_ENABLE       = 1'b1,
   parameter int unsigned       SHA_RANGE_WIDTH  = 4,
   parameter logic [ADDR_W-1:0] SHA_RANGE_MATCH  = 'hd,

   // Network adapter at 0xe0000000-0xefffffff
   parameter bit                NA_ENABLE        = 1'b1,
   parameter int unsigned       NA_RANGE_WIDTH   = 4,
   parameter logic [ADDR_W-1:0] NA_RANGE_MATCH   = 'he,

   // AES-192 at 0xf0000000-0xffffffff
   parameter bit                AES_ENABLE       = 1'b1,
   parameter int unsigned       AES_RANGE_WIDTH  = 4,
   parameter logic [ADDR_W-1:0] AES_RANGE_MATCH  = 'hf,

   parameter int unsigned       TIMEOUT_CYCLES   = 16
) (
   input  wire          clk,
   input  wire          arst_n_i,

   input  wire wb_m2s_t m_req_i,         // Tile port master
   output wb_s2m_t      m_rsp_o,

   output wb_m2s_t      s_req_o [NR_SLAVES],
   input  wire wb_s2m_t s_rsp_i [NR_SLAVES]
);

   // Slot tables, index 0 is DES3
   localparam logic [NR_SLAVES-1:0][RANGE_W_W-1:0] RANGE_WIDTH = {
      RANGE_W_W'(AES_RANGE_WIDTH),
      RANGE_W_W'(NA_RANGE_WIDTH),
      RANGE_W_W'(SHA_RANGE_WIDTH),
      RANGE_W_W'(DES3_RANGE_WIDTH)
   };

   localparam logic [NR_SLAVES-1:0][ADDR_W-1:0] RANGE_MATCH = {
      AES_RANGE_MATCH,
      NA_RANGE_MATCH,
      SHA_RANGE_MATCH,
      DES3_RANGE_MATCH
   };

   localparam logic [NR_SLAVES-1:0] ENABLE = {
      AES_ENABLE,
      NA_ENABLE,
      SHA_ENABLE,
      DES3_ENABLE
   };

   slave_e sel_slave;                    // Decoded target of the current request

   crypto_bus_decode #(
      .RANGE_WIDTH (RANGE_WIDTH),
      .RANGE_MATCH (RANGE_MATCH),
      .ENABLE      (ENABLE)
   ) u_decode (
      .adr_i       (m_req_i.adr),
      .sel_slave_o (sel_slave)
   );

   crypto_bus_fabric #(
      .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
   ) u_fabric (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .m_req_i     (m_req_i),
      .sel_slave_i (sel_slave),
      .m_rsp_o     (m_rsp_o),
      .s_req_o     (s_req_o),
      .s_rsp_i     (s_rsp_i)
   );

endmodule

`default_nettype wire

//--- wb_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module wb_slave_model
   import crypto_bus_pkg::*;
#(
   parameter int unsigned SLOT      = 0,      // Tag XOR-ed into read data
   parameter int unsigned ACK_DELAY = 0,      // Extra wait cycles before ack
   parameter bit          NO_ACK    = 1'b0    // Never answer
) (
   input  wire          clk,
   input  wire          arst_n_i,
   input  wire wb_m2s_t req_i,
   output wb_s2m_t      rsp_o
);

   logic [DATA_W-1:0] data_q;                 // The one data register
   logic [DATA_W-1:0] rdat_q;
   logic [7:0]        cnt_q;
   logic              ack_q;
   logic              req;

   assign req = req_i.cyc && req_i.stb;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         data_q <= '0;
         rdat_q <= '0;
         cnt_q  <= '0;
         ack_q  <= 1'b0;
      end else begin
         ack_q <= 1'b0;                        // Single cycle ack
         if (!req) begin
            cnt_q <= '0;
         end else if (!ack_q && !NO_ACK) begin
            if (cnt_q == 8'(ACK_DELAY)) begin
               ack_q <= 1'b1;
               cnt_q <= '0;
               if (req_i.we) begin
                  data_q <= req_i.dat;
                  rdat_q <= '0;
               end else begin
                  rdat_q <= data_q ^ {8'(SLOT), 24'h000000};   // Slot in top byte
               end
            end else begin
               cnt_q <= cnt_q + 1'b1;
            end
         end
      end
   end

   assign rsp_o.dat = ack_q ? rdat_q : '0;
   assign rsp_o.ack = ack_q;
   assign rsp_o.err = 1'b0;

endmodule

`default_nettype wire

//--- cryptosubsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cryptosubsys_tb
   import crypto_bus_pkg::*;
();

   localparam int unsigned WAIT_LIMIT     = 64;
   localparam int unsigned TIMEOUT_CYCLES = 16;   // Same as the top level
   localparam int unsigned EXP_DEPTH      = 64;

   logic    clk = 1'b0;
   logic    arst_n;
   wb_m2s_t m_req;
   wb_s2m_t m_rsp;
   wb_m2s_t s_req [NR_SLAVES];
   wb_s2m_t s_rsp [NR_SLAVES];

   integer            seed;
   slave_e            exp_slot;                  // Slot allowed to see stb
   logic [DATA_W-1:0] shadow [NR_SLAVES];        // Expected model registers
   wb_s2m_t           exp_mem [EXP_DEPTH];       // Expected responses in order
   int unsigned       exp_wr;
   int unsigned       exp_rd;
   int unsigned       na_stb_cnt;

   always #2 clk = ~clk;

   cryptosubsys_top UUT (
      .clk      (clk),
      .arst_n_i (arst_n),
      .m_req_i  (m_req),
      .m_rsp_o  (m_rsp),
      .s_req_o  (s_req),
      .s_rsp_i  (s_rsp)
   );

   // Slot 2 never answers, the others wait 0, 2 and 5 cycles
   for (genvar i = 0; i < NR_SLAVES; i++) begin : gen_model
      wb_slave_model #(
         .SLOT      (i),
         .ACK_DELAY ((i == 1) ? 2 : ((i == 3) ? 5 : 0)),
         .NO_ACK    (i == 2)
      ) u_model (
         .clk      (clk),
         .arst_n_i (arst_n),
         .req_i    (s_req[i]),
         .rsp_o    (s_rsp[i])
      );
   end

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "Stopped at first failure");
   endtask

   // Address map of the tile
   function automatic slave_e ref_slot(input logic [ADDR_W-1:0] adr);
      if (!adr[31]) begin
         return SLV_DES3;
      end
      case (adr[31:28])
         4'hd:    return SLV_SHA;
         4'he:    return SLV_NA;
         4'hf:    return SLV_AES;
         default: return SLV_NONE;
      endcase
   endfunction

   // Unmapped and network adapter accesses both end in a fabric err
   function automatic wb_s2m_t ref_rsp(input slave_e slot, input logic we,
                                       input logic [DATA_W-1:0] stored);
      wb_s2m_t rsp;
      rsp = '0;
      if (slot == SLV_NONE || slot == SLV_NA) begin
         rsp.err = 1'b1;
      end else begin
         rsp.ack = 1'b1;
         if (!we) begin
            rsp.dat = stored ^ {5'd0, slot, 24'h000000};
         end
      end
      return rsp;
   endfunction

   function automatic logic [ADDR_W-1:0] slot_addr(input slave_e slot, input logic [31:0] r);
      case (slot)
         SLV_DES3: return {1'b0, r[30:2], 2'b00};
         SLV_SHA:  return {4'hd, r[27:2], 2'b00};
         SLV_NA:   return {4'he, r[27:2], 2'b00};
         default:  return {4'hf, r[27:2], 2'b00};
      endcase
   endfunction

   task automatic check_rsp(input wb_s2m_t got, input wb_s2m_t exp);
      if (got !== exp) begin
         fail_stop($sformatf(
            "[ERROR] %0t: m_rsp_o dat=%08h ack=%b err=%b, expected dat=%08h ack=%b err=%b",
            $time, got.dat, got.ack, got.err, exp.dat, exp.ack, exp.err));
      end
   endtask

   task automatic check_slave(input slave_e got, input slave_e exp);
      if (got !== exp) begin
         fail_stop($sformatf("[ERROR] %0t: stb raised for slot %s, expected %s",
                             $time, got.name(), exp.name()));
      end
   endtask

   // Address, data, select and write enable reach every slot unchanged
   task automatic check_fanout(input wb_m2s_t got, input wb_m2s_t exp);
      if (got.adr !== exp.adr || got.dat !== exp.dat || got.sel !== exp.sel ||
          got.we !== exp.we) begin
         fail_stop($sformatf(
            "[ERROR] %0t: s_req_o adr=%08h dat=%08h sel=%h we=%b, expected %08h %08h %h %b",
            $time, got.adr, got.dat, got.sel, got.we, exp.adr, exp.dat, exp.sel, exp.we));
      end
   endtask

   function automatic logic any_stb();
      logic hit;
      hit = 1'b0;
      for (int i = 0; i < NR_SLAVES; i++) begin
         hit = hit | s_req[i].stb;
      end
      return hit;
   endfunction

   task automatic check_idle(input int unsigned n);
      for (int k = 0; k < n; k++) begin
         @(posedge clk);
         for (int i = 0; i < NR_SLAVES; i++) begin
            if (s_req[i].cyc || s_req[i].stb) begin
               fail_stop($sformatf("[ERROR] %0t: slot %0d cyc=%b stb=%b while the master is idle",
                                   $time, i, s_req[i].cyc, s_req[i].stb));
            end
         end
         if (m_rsp.ack || m_rsp.err) begin
            fail_stop($sformatf("[ERROR] %0t: m_rsp_o ack=%b err=%b while the master is idle",
                                $time, m_rsp.ack, m_rsp.err));
         end
      end
   endtask

   task automatic go_idle();
      m_req.cyc <= 1'b0;
      m_req.stb <= 1'b0;
      m_req.sel <= '0;
   endtask

   // Starts one access on the current edge and returns on the edge that sees the answer
   task automatic do_access(input logic [ADDR_W-1:0] adr, input logic we,
                            input logic [DATA_W-1:0] dat, output int unsigned cycles);
      slave_e            slot;
      wb_m2s_t           req;
      logic [DATA_W-1:0] stored;
      logic              done;
      slot   = ref_slot(adr);
      stored = (slot == SLV_NONE) ? '0 : shadow[slot[1:0]];
      exp_mem[exp_wr % EXP_DEPTH] = ref_rsp(slot, we, stored);
      exp_wr = exp_wr + 1;
      if (we && slot != SLV_NONE && slot != SLV_NA) begin
         shadow[slot[1:0]] = dat;
      end
      req     = '0;
      req.adr = adr;
      req.dat = dat;
      req.sel = '1;
      req.we  = we;
      req.cyc = 1'b1;
      req.stb = 1'b1;
      m_req    <= req;
      exp_slot <= slot;
      cycles = 0;
      done   = 1'b0;
      while (!done) begin
         @(posedge clk);
         cycles = cycles + 1;
         if (m_rsp.ack || m_rsp.err) begin
            done = 1'b1;
            if (m_rsp.err && any_stb()) begin
               fail_stop("Slave stb still high while err returns to the master");
            end
         end else if (cycles >= WAIT_LIMIT) begin
            fail_stop($sformatf("Timeout: no ack or err for address %08h in %0d cycles",
                                adr, WAIT_LIMIT));
         end
      end
   endtask

   // Compares every response and every slave request with the reference
   always @(posedge clk) begin : compare
      int unsigned n_stb;
      slave_e      got;
      if (arst_n) begin
         n_stb = 0;
         got   = SLV_NONE;
         for (int i = 0; i < NR_SLAVES; i++) begin
            check_fanout(s_req[i], m_req);
            if (s_req[i].cyc !== s_req[i].stb) begin
               fail_stop($sformatf("[ERROR] %0t: slot %0d cyc=%b differs from stb=%b",
                                   $time, i, s_req[i].cyc, s_req[i].stb));
            end
            if (s_req[i].stb) begin
               n_stb = n_stb + 1;
               got   = slave_e'(i);
            end
         end
         if (s_req[SLV_NA].stb) begin
            na_stb_cnt = na_stb_cnt + 1;
         end
         if (n_stb > 1) begin
            fail_stop("More than one slave stb high at once");
         end else if (n_stb == 1) begin
            check_slave(got, exp_slot);
         end
         if (m_rsp.ack || m_rsp.err) begin
            if (exp_rd == exp_wr) begin
               fail_stop("Response on m_rsp_o with no access outstanding");
            end else begin
               check_rsp(m_rsp, exp_mem[exp_rd % EXP_DEPTH]);
               exp_rd = exp_rd + 1;
            end
         end
      end
   end

   initial begin : stimulus
      int unsigned       cycles;
      int unsigned       na_before;
      logic [31:0]       r;
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
      slave_e            slot;
      m_req    <= '0;
      arst_n   <= 1'b0;
      exp_slot <= SLV_NONE;
      seed       = 6;
      exp_wr     = 0;
      exp_rd     = 0;
      na_stb_cnt = 0;
      for (int i = 0; i < NR_SLAVES; i++) begin
         shadow[i] = '0;
      end
      repeat (3) @(posedge clk);
      arst_n <= 1'b1;
      check_idle(4);

      // Write then read back in each mapped range
      for (int n = 0; n < 9; n++) begin
         slot = (n % 3 == 0) ? SLV_DES3 : ((n % 3 == 1) ? SLV_SHA : SLV_AES);
         r    = $random(seed);
         adr  = slot_addr(slot, r);
         dat  = $random(seed);
         do_access(adr, 1'b1, dat, cycles);
         go_idle();
         @(posedge clk);
         do_access(adr, 1'b0, '0, cycles);
         go_idle();
         @(posedge clk);
      end

      // Unmapped addresses, err one cycle after the fabric sees stb
      do_access(32'h9000_0000, 1'b0, '0, cycles);
      go_idle();
      if (cycles != 2) begin
         fail_stop($sformatf("[ERROR] %0t: unmapped err after %0d cycles, expected 2",
                             $time, cycles));
      end
      check_idle(2);
      do_access(32'hc000_1234, 1'b1, 32'h1234_5678, cycles);
      go_idle();
      if (cycles != 2) begin
         fail_stop($sformatf("[ERROR] %0t: unmapped err after %0d cycles, expected 2",
                             $time, cycles));
      end
      check_idle(2);

      // Silent network adapter, the watchdog answers
      na_before = na_stb_cnt;
      r = $random(seed);
      do_access(slot_addr(SLV_NA, r), 1'b0, '0, cycles);
      go_idle();
      if (na_stb_cnt == na_before) begin
         fail_stop("Network adapter stb never rose");
      end
      if (cycles != TIMEOUT_CYCLES + 1) begin
         fail_stop($sformatf("[ERROR] %0t: watchdog err after %0d cycles, expected %0d",
                             $time, cycles, TIMEOUT_CYCLES + 1));
      end
      check_idle(2);

      // Back to back over slots with different delays
      for (int n = 0; n < 3; n++) begin
         slot = slave_e'((n == 2) ? 3 : n);
         r    = $random(seed);
         dat  = $random(seed);
         do_access(slot_addr(slot, r), 1'b1, dat, cycles);
      end
      for (int n = 0; n < 8; n++) begin
         r    = $random(seed);
         slot = (r[1:0] == 2'd0) ? SLV_DES3 : ((r[1:0] == 2'd1) ? SLV_SHA : SLV_AES);
         do_access(slot_addr(slot, r), 1'b0, '0, cycles);
      end
      go_idle();
      check_idle(2);

      if (exp_rd == exp_wr) begin
         $display("Simulation passed");
         $finish;
      end else begin
         fail_stop("Some accesses never got a response checked");
      end
   end

endmodule

`default_nettype wire

//--- files.f
crypto_bus_pkg.sv
crypto_bus_decode.sv
crypto_bus_fabric.sv
cryptosubsys_top.sv
wb_slave_model.sv
cryptosubsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the crypto bus testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
EXE=cryptosubsys_sim

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --timing --assert \
   --top-module cryptosubsys_tb \
   -f files.f \
   -Mdir "$OBJ" -o "$EXE"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation run returned status $status"
fi

if grep -q "^Simulation passed$" "$LOG"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi
